//--- Bender.yml
package:
  name: ring_subsystem

sources:
  # design
  - files:
      - hw/ringPkg.sv
      - hw/ringRequester.sv
      - hw/ringBridge.sv
      - hw/ringMemory.sv
      - hw/ringSubsystem.sv

  # testbench and assertions
  - target: simulation
    files:
      - sim/ringBridge_sva.sv
      - sim/ringSubsystemTb.sv

//--- hw/ringBridge.sv
`timescale 1ns/1ps

module ringBridge (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [ringPkg::seqWidth-1:0]  l1SeqIn,	// first ring, from requester
	input  ringPkg::opmE                  l1OpmIn,
	input  logic [ringPkg::addrWidth-1:0] l1AddrIn,
	input  logic [ringPkg::dataWidth-1:0] l1DataIn,
	output logic [ringPkg::seqWidth-1:0]  l1SeqOut,	// first ring, back to requester
	output ringPkg::opmE                  l1OpmOut,
	output logic [ringPkg::addrWidth-1:0] l1AddrOut,
	output logic [ringPkg::dataWidth-1:0] l1DataOut,
	input  logic [ringPkg::seqWidth-1:0]  l2SeqIn,	// second ring, from memory
	input  ringPkg::opmE                  l2OpmIn,
	input  logic [ringPkg::addrWidth-1:0] l2AddrIn,
	input  logic [ringPkg::dataWidth-1:0] l2DataIn,
	output logic [ringPkg::seqWidth-1:0]  l2SeqOut,	// second ring, toward memory
	output ringPkg::opmE                  l2OpmOut,
	output logic [ringPkg::addrWidth-1:0] l2AddrOut,
	output logic [ringPkg::dataWidth-1:0] l2DataOut
);

	logic l1Idle;	// first ring slot empty
	logic l1Req;	// first ring slot is a request
	logic l2Idle;	// second ring slot empty
	logic l2Resp;	// response for our group
	logic holdL1;	// first ring slot must stay on its ring
	logic holdL2;	// second ring slot must stay on its ring

	logic [ringPkg::seqWidth-1:0]  l1SeqNxt;
	ringPkg::opmE                  l1OpmNxt;
	logic [ringPkg::addrWidth-1:0] l1AddrNxt;
	logic [ringPkg::dataWidth-1:0] l1DataNxt;
	logic [ringPkg::seqWidth-1:0]  l2SeqNxt;
	ringPkg::opmE                  l2OpmNxt;
	logic [ringPkg::addrWidth-1:0] l2AddrNxt;
	logic [ringPkg::dataWidth-1:0] l2DataNxt;

	// slot classes
	assign l1Idle = (l1OpmIn == ringPkg::opIdle);
	assign l1Req  = (l1OpmIn[7:6] == 2'b10);
	assign l2Idle = (l2OpmIn == ringPkg::opIdle);
	assign l2Resp = (l2OpmIn[7:6] == 2'b01) && (l2SeqIn[15:10] == ringPkg::groupId);

	assign holdL1 = !l1Idle && !l1Req;	// nothing it carries may cross
	assign holdL2 = !l2Idle && !l2Resp;	// other groups and requests stay on ring 2

	// toward the first ring
	always_comb
	begin
		if ((l1Idle || l1Req) && !holdL2)
		begin
			if (l2Resp)
			begin
				l1SeqNxt  = l2SeqIn;	// response comes home
				l1OpmNxt  = l2OpmIn;
				l1AddrNxt = l2AddrIn;
				l1DataNxt = l2DataIn;
			end
			else
			begin
				l1SeqNxt  = '0;	// nothing carried over
				l1OpmNxt  = ringPkg::opIdle;
				l1AddrNxt = '0;
				l1DataNxt = '0;
			end
		end
		else
		begin
			l1SeqNxt  = l1SeqIn;	// circulate on ring 1
			l1OpmNxt  = l1OpmIn;
			l1AddrNxt = l1AddrIn;
			l1DataNxt = l1DataIn;
		end
	end

	// toward the second ring
	always_comb
	begin
		if ((l2Idle || l2Resp) && !holdL1)
		begin
			if (l1Req)
			begin
				l2SeqNxt  = l1SeqIn;	// request crosses to memory ring
				l2OpmNxt  = l1OpmIn;
				l2AddrNxt = l1AddrIn;
				l2DataNxt = l1DataIn;
			end
			else
			begin
				l2SeqNxt  = '0;
				l2OpmNxt  = ringPkg::opIdle;
				l2AddrNxt = '0;
				l2DataNxt = '0;
			end
		end
		else
		begin
			l2SeqNxt  = l2SeqIn;	// busy target, go round again
			l2OpmNxt  = l2OpmIn;
			l2AddrNxt = l2AddrIn;
			l2DataNxt = l2DataIn;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			l1SeqOut <= '0;	// both rings start empty
			l1OpmOut <= ringPkg::opIdle;
			l2SeqOut <= '0;
			l2OpmOut <= ringPkg::opIdle;
		end
		else
		begin
			l1SeqOut <= l1SeqNxt;
			l1OpmOut <= l1OpmNxt;
			l2SeqOut <= l2SeqNxt;
			l2OpmOut <= l2OpmNxt;
		end
	end

	// payload only
	always_ff @(posedge clock)
	begin
		l1AddrOut <= l1AddrNxt;
		l1DataOut <= l1DataNxt;
		l2AddrOut <= l2AddrNxt;
		l2DataOut <= l2DataNxt;
	end

endmodule

//--- hw/ringMemory.sv
`timescale 1ns/1ps

module ringMemory (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [ringPkg::seqWidth-1:0]  seqIn,	// slot from the bridge
	input  ringPkg::opmE                  opmIn,
	input  logic [ringPkg::addrWidth-1:0] addrIn,
	input  logic [ringPkg::dataWidth-1:0] dataIn,
	output logic [ringPkg::seqWidth-1:0]  seqOut,	// slot back to the bridge
	output ringPkg::opmE                  opmOut,
	output logic [ringPkg::addrWidth-1:0] addrOut,
	output logic [ringPkg::dataWidth-1:0] dataOut
);

	logic [ringPkg::dataWidth-1:0] mem [ringPkg::memWords];	// word storage

	logic [3:0] idx;	// word index, bits 6..3
	logic       isLoad;
	logic       isStore;

	assign idx     = addrIn[6:3];	// higher bits ignored, so addresses alias
	assign isLoad  = (opmIn == ringPkg::opLoad);
	assign isStore = (opmIn == ringPkg::opStore);

	// array and slot header
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < ringPkg::memWords; i++)
			begin
				mem[i] <= '0;	// loads of unwritten words read zero
			end
			seqOut <= '0;
			opmOut <= ringPkg::opIdle;
		end
		else
		begin
			if (isStore)
				mem[idx] <= dataIn;	// written as the request arrives

			seqOut <= seqIn;	// sequence kept so the requester can match it
			if (isLoad)
				opmOut <= ringPkg::opLoadResp;
			else if (isStore)
				opmOut <= ringPkg::opStoreResp;
			else
				opmOut <= opmIn;	// idle and responses pass
		end
	end

	// payload
	always_ff @(posedge clock)
	begin
		addrOut <= addrIn;	// address travels back unchanged
		if (isLoad)
			dataOut <= mem[idx];	// old contents, store of same cycle not seen
		else
			dataOut <= dataIn;	// store echoes its data
	end

endmodule

//--- hw/ringPkg.sv
package ringPkg;

	// slot field widths
	localparam int seqWidth  = 16;	// group id 15..10, serial 9..0
	localparam int opmWidth  = 8;	// operation code
	localparam int addrWidth = 32;	// byte address
	localparam int dataWidth = 64;	// one data word per slot

	// first ring group, carried in the sequence word
	localparam logic [5:0] groupId = 6'h05;	// bridge pulls these responses off ring 2

	// memory node depth, indexed by address bits 6..3
	localparam int memWords = 16;	// aliases every 128 bytes

	// operation codes
	// top two bits tell the class: 10 request, 01 response, all zero idle
	typedef enum logic [opmWidth-1:0] {
		opIdle      = 8'h00,	// empty slot
		opLoad      = 8'h80,	// read one word
		opStore     = 8'h81,	// write one word
		opLoadResp  = 8'h40,	// read data returned
		opStoreResp = 8'h41		// write done, data echoed
	} opmE;

endpackage

//--- hw/ringRequester.sv
`timescale 1ns/1ps

module ringRequester (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             reqValid,	// command strobe, honoured when not busy
	input  logic                             reqStore,	// 1 store, 0 load
	input  logic [ringPkg::addrWidth-1:0]    reqAddr,	// command address
	input  logic [ringPkg::dataWidth-1:0]    reqData,	// store data
	output logic                             busy,		// pending command not yet injected
	output logic                             respValid,	// one-cycle response pulse
	output logic                             respStore,	// response was for a store
	output logic [ringPkg::seqWidth-1:0]     respSeq,	// sequence of the answered command
	output logic [ringPkg::dataWidth-1:0]    respData,	// load data or echoed store data
	input  logic [ringPkg::seqWidth-1:0]     seqIn,		// slot from the bridge
	input  ringPkg::opmE                     opmIn,
	input  logic [ringPkg::addrWidth-1:0]    addrIn,
	input  logic [ringPkg::dataWidth-1:0]    dataIn,
	output logic [ringPkg::seqWidth-1:0]     seqOut,	// slot toward the bridge
	output ringPkg::opmE                     opmOut,
	output logic [ringPkg::addrWidth-1:0]    addrOut,
	output logic [ringPkg::dataWidth-1:0]    dataOut
);

	logic                          pendValid;		// command waiting for an idle slot
	logic                          pendStore;
	logic [ringPkg::addrWidth-1:0] pendAddr;
	logic [ringPkg::dataWidth-1:0] pendData;
	logic [9:0]                    pendSerial;		// serial stamped at acceptance
	logic [9:0]                    serialNext;		// next free serial
	logic [1023:0]                 outstanding;		// one bit per serial in flight

	logic inIdle;		// incoming slot empty
	logic inOwnResp;	// response carrying our group id
	logic accept;		// command taken this edge
	logic inject;		// pending command goes out this edge

	assign inIdle    = (opmIn == ringPkg::opIdle);
	assign inOwnResp = (opmIn[7:6] == 2'b01) && (seqIn[15:10] == ringPkg::groupId);
	assign accept    = reqValid && !pendValid;
	assign inject    = pendValid && inIdle;
	assign busy      = pendValid;	// rises at acceptance, falls at injection

	// control state and slot header
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pendValid   <= 1'b0;
			serialNext  <= '0;
			outstanding <= '0;
			respValid   <= 1'b0;
			seqOut      <= '0;
			opmOut      <= ringPkg::opIdle;
		end
		else
		begin
			if (accept)
			begin
				pendValid  <= 1'b1;
				serialNext <= serialNext + 10'd1;	// wraps after 1024
			end
			else if (inject)
				pendValid <= 1'b0;

			respValid <= inOwnResp && outstanding[seqIn[9:0]];	// stray serials dropped silently

			if (inOwnResp)
				outstanding[seqIn[9:0]] <= 1'b0;
			if (inject)
				outstanding[pendSerial] <= 1'b1;

			if (inject)
			begin
				seqOut <= {ringPkg::groupId, pendSerial};
				opmOut <= pendStore ? ringPkg::opStore : ringPkg::opLoad;
			end
			else if (inOwnResp)
			begin
				seqOut <= '0;	// slot freed after capture
				opmOut <= ringPkg::opIdle;
			end
			else
			begin
				seqOut <= seqIn;	// pass along
				opmOut <= opmIn;
			end
		end
	end

	// payload, no reset needed
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			pendStore  <= reqStore;
			pendAddr   <= reqAddr;
			pendData   <= reqData;
			pendSerial <= serialNext;
		end
		if (inOwnResp)
		begin
			respStore <= (opmIn == ringPkg::opStoreResp);
			respSeq   <= seqIn;
			respData  <= dataIn;
		end
		addrOut <= inject ? pendAddr : addrIn;
		dataOut <= inject ? pendData : dataIn;
	end

endmodule

//--- hw/ringSubsystem.sv
`timescale 1ns/1ps

module ringSubsystem (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          reqValid,	// command strobe
	input  logic                          reqStore,
	input  logic [ringPkg::addrWidth-1:0] reqAddr,
	input  logic [ringPkg::dataWidth-1:0] reqData,
	output logic                          busy,		// hold off reqValid while high
	output logic                          respValid,
	output logic                          respStore,
	output logic [ringPkg::seqWidth-1:0]  respSeq,
	output logic [ringPkg::dataWidth-1:0] respData
);

	// first ring, requester to bridge
	logic [ringPkg::seqWidth-1:0]  l1FwdSeq;
	ringPkg::opmE                  l1FwdOpm;
	logic [ringPkg::addrWidth-1:0] l1FwdAddr;
	logic [ringPkg::dataWidth-1:0] l1FwdData;
	// first ring, bridge back to requester
	logic [ringPkg::seqWidth-1:0]  l1RetSeq;
	ringPkg::opmE                  l1RetOpm;
	logic [ringPkg::addrWidth-1:0] l1RetAddr;
	logic [ringPkg::dataWidth-1:0] l1RetData;
	// second ring, bridge to memory
	logic [ringPkg::seqWidth-1:0]  l2FwdSeq;
	ringPkg::opmE                  l2FwdOpm;
	logic [ringPkg::addrWidth-1:0] l2FwdAddr;
	logic [ringPkg::dataWidth-1:0] l2FwdData;
	// second ring, memory back to bridge
	logic [ringPkg::seqWidth-1:0]  l2RetSeq;
	ringPkg::opmE                  l2RetOpm;
	logic [ringPkg::addrWidth-1:0] l2RetAddr;
	logic [ringPkg::dataWidth-1:0] l2RetData;

	ringRequester ringRequester_inst (
		.clock(clock), .reset(reset),
		.reqValid(reqValid), .reqStore(reqStore), .reqAddr(reqAddr), .reqData(reqData),
		.busy(busy), .respValid(respValid), .respStore(respStore),
		.respSeq(respSeq), .respData(respData),
		.seqIn(l1RetSeq), .opmIn(l1RetOpm), .addrIn(l1RetAddr), .dataIn(l1RetData),
		.seqOut(l1FwdSeq), .opmOut(l1FwdOpm), .addrOut(l1FwdAddr), .dataOut(l1FwdData)
	);

	ringBridge ringBridge_inst (
		.clock(clock), .reset(reset),
		.l1SeqIn(l1FwdSeq), .l1OpmIn(l1FwdOpm), .l1AddrIn(l1FwdAddr), .l1DataIn(l1FwdData),
		.l1SeqOut(l1RetSeq), .l1OpmOut(l1RetOpm), .l1AddrOut(l1RetAddr), .l1DataOut(l1RetData),
		.l2SeqIn(l2RetSeq), .l2OpmIn(l2RetOpm), .l2AddrIn(l2RetAddr), .l2DataIn(l2RetData),
		.l2SeqOut(l2FwdSeq), .l2OpmOut(l2FwdOpm), .l2AddrOut(l2FwdAddr), .l2DataOut(l2FwdData)
	);

	ringMemory ringMemory_inst (
		.clock(clock), .reset(reset),
		.seqIn(l2FwdSeq), .opmIn(l2FwdOpm), .addrIn(l2FwdAddr), .dataIn(l2FwdData),
		.seqOut(l2RetSeq), .opmOut(l2RetOpm), .addrOut(l2RetAddr), .dataOut(l2RetData)
	);

endmodule

//--- list.f
hw/ringPkg.sv
hw/ringRequester.sv
hw/ringBridge.sv
hw/ringMemory.sv
hw/ringSubsystem.sv
sim/ringBridge_sva.sv
sim/ringSubsystemTb.sv

//--- sim/ringBridge_sva.sv
`timescale 1ns/1ps

module ringBridgeSva (
	input logic                         clock,
	input logic                         reset,
	input logic [ringPkg::seqWidth-1:0] l1SeqIn,
	input logic [ringPkg::opmWidth-1:0] l1OpmIn,
	input logic                         l2Idle,	// bridge slot class
	input logic                         l2Resp,
	input logic [ringPkg::seqWidth-1:0] l2SeqOut,
	input logic [ringPkg::opmWidth-1:0] l1OpmOut,
	input logic [ringPkg::opmWidth-1:0] l2OpmOut
);

	// both rings empty after a reset edge
	resetIdle: assert property (@(posedge clock)
		reset |=> (l1OpmOut == ringPkg::opIdle) && (l2OpmOut == ringPkg::opIdle))
		else $error("bridge output not idle after reset");

	// request crosses when ring 2 slot is free
	requestCross: assert property (@(posedge clock) disable iff (reset)
		(l1OpmIn[7:6] == 2'b10) && (l2Idle || l2Resp)
		|=> (l2OpmOut == $past(l1OpmIn)) && (l2SeqOut == $past(l1SeqIn)))
		else $error("first ring request did not reach the second ring");

	// a request on ring 1 out can only be one circulating on ring 1
	noRequestBack: assert property (@(posedge clock) disable iff (reset)
		(l1OpmIn[7:6] != 2'b10) |=> (l1OpmOut[7:6] != 2'b10))
		else $error("second ring request leaked onto the first ring");

endmodule

bind ringBridge ringBridgeSva ringBridgeSva_inst (
	.clock(clock), .reset(reset), .l1SeqIn(l1SeqIn), .l1OpmIn(l1OpmIn),
	.l2Idle(l2Idle), .l2Resp(l2Resp), .l2SeqOut(l2SeqOut), .l1OpmOut(l1OpmOut),
	.l2OpmOut(l2OpmOut)
);

//--- sim/ringSubsystemTb.sv
`timescale 1ns/1ps

module ringSubsystemTb;

	localparam int maxCycles   = 2000;	// about 300 cycles of tests, wide margin
	localparam int respTimeout = 100;	// one round trip is a handful of cycles
	localparam int busyTimeout = 50;

	logic        clock;
	logic        reset;
	logic        reqValid;
	logic        reqStore;
	logic [31:0] reqAddr;
	logic [63:0] reqData;
	logic        busy;
	logic        respValid;
	logic        respStore;
	logic [15:0] respSeq;
	logic [63:0] respData;

	logic [63:0] refMem [ringPkg::memWords];	// reference memory, address bits 6..3
	logic [15:0] seenSeq [$];	// responses caught by the monitor
	logic [63:0] seenData [$];
	logic        seenStore [$];
	logic [9:0]  nextSerial;	// serial the requester stamps next
	int          seed;
	int          cycleCount;
	int          checkCount;
	int          errorCount;
	int          testErrors;	// error count when the current test began

	ringSubsystem ringSubsystem_inst (
		.clock(clock), .reset(reset), .reqValid(reqValid), .reqStore(reqStore),
		.reqAddr(reqAddr), .reqData(reqData), .busy(busy), .respValid(respValid),
		.respStore(respStore), .respSeq(respSeq), .respData(respData)
	);

	always #5 clock = ~clock;	// 10 ns period

	// response pulses sampled mid-cycle
	always @(negedge clock)
	begin
		if (respValid === 1'b1)
		begin
			seenSeq.push_back(respSeq);
			seenData.push_back(respData);
			seenStore.push_back(respStore);
		end
	end

	// run limit
	initial
	begin
		cycleCount = 0;
		while (cycleCount < maxCycles)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", maxCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name);
		$display("%s done, %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// one command, strobe honoured only while busy is low
	task automatic issueCommand(input logic store, input logic [31:0] addr,
		input logic [63:0] data, output logic [15:0] seq, output logic [63:0] expData);
		int waited;
		waited = 0;
		while (busy && waited < busyTimeout)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		checkCount++;
		assert (!busy)
		else
		begin
			$display("busy stayed high for %0d cycles, command not issued", busyTimeout);
			errorCount++;
		end
		seq = {ringPkg::groupId, nextSerial};
		if (store)
			refMem[addr[6:3]] = data;	// memory serves requests in issue order
		expData = refMem[addr[6:3]];
		if (!busy)
		begin
			reqValid = 1'b1;
			reqStore = store;
			reqAddr  = addr;
			reqData  = data;
			@(posedge clock);
			#1;
			reqValid   = 1'b0;
			nextSerial = nextSerial + 10'd1;
		end
	endtask

	task automatic collectResponse(output logic got, output logic [15:0] seq,
		output logic [63:0] data, output logic store);
		int waited;
		waited = 0;
		while (seenSeq.size() == 0 && waited < respTimeout)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		got = (seenSeq.size() != 0);
		checkCount++;
		assert (got)
		else
		begin
			$display("no response arrived within %0d cycles", respTimeout);
			errorCount++;
		end
		seq   = got ? seenSeq.pop_front() : '0;
		data  = got ? seenData.pop_front() : '0;
		store = got ? seenStore.pop_front() : 1'b0;
	endtask

	task automatic runCommand(input logic store, input logic [31:0] addr, input logic [63:0] data);
		logic [15:0] seq;
		logic [63:0] expData;
		logic        got;
		logic [15:0] gotSeq;
		logic [63:0] gotData;
		logic        gotStore;
		issueCommand(store, addr, data, seq, expData);
		collectResponse(got, gotSeq, gotData, gotStore);
		if (got)
		begin
			checkValue("respSeq", seq, gotSeq);	// group id in bits 15..10
			checkValue("respStore", store, gotStore);
			checkValue("respData", expData, gotData);
		end
	endtask

	task automatic resetIdleTest();
		repeat (20)
		begin
			@(posedge clock);
			#1;
			checkValue("busy", 0, busy);
			checkValue("respValid", 0, respValid);
		end
		checkValue("response count", 0, seenSeq.size());
		reportTest("reset idle");
	endtask

	task automatic storeLoadTest();
		logic [63:0] data;
		data = {$random(seed), $random(seed)};
		runCommand(1'b1, 32'h0000_1018, data);
		runCommand(1'b0, 32'h0000_1018, 64'h0);
		reportTest("store then load");
	endtask

	task automatic unwrittenLoadTest();
		runCommand(1'b0, 32'h0000_0040, 64'h0);	// index 8, cleared by reset
		reportTest("unwritten load");
	endtask

	task automatic burstTest();
		logic [15:0] burstSeq [8];
		logic        burstStoreFlag [8];
		logic [63:0] burstExp [8];
		logic        burstSeen [8];
		logic [31:0] addr;
		logic        got;
		logic [15:0] gotSeq;
		logic [63:0] gotData;
		logic        gotStore;
		int          match;
		for (int i = 0; i < 8; i++)
		begin
			if (i % 2 == 0)
				addr = $random(seed);	// odd slots load back the previous store
			burstStoreFlag[i] = (i % 2 == 0);
			burstSeen[i]      = 1'b0;
			issueCommand(burstStoreFlag[i], addr, {$random(seed), $random(seed)},
				burstSeq[i], burstExp[i]);
		end
		for (int n = 0; n < 8; n++)
		begin
			collectResponse(got, gotSeq, gotData, gotStore);
			match = -1;
			for (int k = 0; k < 8; k++)
				if (got && !burstSeen[k] && burstSeq[k] == gotSeq)
					match = k;
			checkCount++;
			assert (!got || match >= 0)
			else
			begin
				$display("Fail respSeq %h matches no command in flight", gotSeq);
				errorCount++;
			end
			if (match >= 0)
			begin
				burstSeen[match] = 1'b1;
				checkValue("respStore", burstStoreFlag[match], gotStore);
				checkValue("respData", burstExp[match], gotData);
			end
		end
		reportTest("burst of eight");
	endtask

	task automatic aliasTest();
		logic [63:0] data;
		data = {$random(seed), $random(seed)};
		runCommand(1'b1, 32'h0000_0210, data);
		runCommand(1'b0, 32'h0000_0290, 64'h0);	// 128 bytes up, same word
		reportTest("address alias");
	endtask

	initial
	begin
		clock      = 1'b0;
		reset      = 1'b1;
		reqValid   = 1'b0;
		reqStore   = 1'b0;
		reqAddr    = '0;
		reqData    = '0;
		seed       = 8;
		nextSerial = '0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		for (int i = 0; i < ringPkg::memWords; i++)
			refMem[i] = '0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		resetIdleTest();
		storeLoadTest();
		unwrittenLoadTest();
		burstTest();
		aliasTest();
		$display("checks: %0d passed, %0d failed", checkCount - errorCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
